/* include/io_consts.svh */
`ifndef IO_CONSTS_SVH
`define IO_CONSTS_SVH

// Bus word and port widths
`define IO_DATA_BITS 32
`define IO_LEDR_BITS 10
`define IO_KEY_BITS 4

// Register map
`define IO_ADDR_HEX 32'hFFFF_F000
`define IO_ADDR_LEDR 32'hFFFF_F020
// Key data, control at +4
`define IO_ADDR_KEY 32'hFFFF_F080
// Timer count, limit at +4, control at +8
`define IO_ADDR_TIMER 32'hFFFF_F100

// Bit positions shared by the key and timer control words
`define IO_CTL_READY 0
`define IO_CTL_OVERRUN 1
`define IO_CTL_IE 4

// Power-up display text
`define IO_HEX_RESET 24'hFEDEAD

// Debounce sample period in clock cycles
`define IO_KEY_SAMPLE_CYCLES 16

`endif

/* rtl/ioPkg.sv */
`include "io_consts.svh"

package ioPkg;

  // One data word or one address on the register bus
  typedef logic [`IO_DATA_BITS-1:0] busWordT;

  // Six display digits, digit 0 is the rightmost
  typedef logic [5:0][3:0] hexDigitsT;

  // Segments g..a, a lit segment is 0
  typedef logic [6:0] segmentT;

endpackage

/* rtl/displayPorts.sv */
`include "io_consts.svh"

module displayPorts (
  input  logic                     clk,
  input  logic                     reset,
  input  ioPkg::busWordT           addr,
  input  ioPkg::busWordT           wrData,
  input  logic                     we,
  output ioPkg::busWordT           rdData,
  output logic [`IO_LEDR_BITS-1:0] ledr,
  output ioPkg::segmentT           hex0,
  output ioPkg::segmentT           hex1,
  output ioPkg::segmentT           hex2,
  output ioPkg::segmentT           hex3,
  output ioPkg::segmentT           hex4,
  output ioPkg::segmentT           hex5
);

  localparam int hexBits = $bits(ioPkg::hexDigitsT);

  logic [`IO_LEDR_BITS-1:0] ledrReg;
  ioPkg::hexDigitsT hexReg;
  logic ledrSel;
  logic hexSel;

  // Board segment patterns, active low
  function automatic ioPkg::segmentT segOf(input logic [3:0] digit);
    case (digit)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'hA: return 7'b0001000;
      4'hB: return 7'b0000011;
      4'hC: return 7'b1000110;
      4'hD: return 7'b0100001;
      4'hE: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  assign ledrSel = (addr == `IO_ADDR_LEDR);
  assign hexSel = (addr == `IO_ADDR_HEX);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ledrReg <= '0;
      hexReg <= `IO_HEX_RESET;
    end else begin
      if (we && ledrSel) begin
        ledrReg <= wrData[`IO_LEDR_BITS-1:0];
      end
      if (we && hexSel) begin
        hexReg <= wrData[hexBits-1:0];
      end
    end
  end

  // Readback, upper bits stay zero
  always_comb begin
    rdData = '0;
    if (ledrSel) begin
      rdData[`IO_LEDR_BITS-1:0] = ledrReg;
    end else if (hexSel) begin
      rdData[hexBits-1:0] = hexReg;
    end
  end

  assign ledr = ledrReg;
  assign hex0 = segOf(hexReg[0]);
  assign hex1 = segOf(hexReg[1]);
  assign hex2 = segOf(hexReg[2]);
  assign hex3 = segOf(hexReg[3]);
  assign hex4 = segOf(hexReg[4]);
  assign hex5 = segOf(hexReg[5]);

endmodule

/* rtl/keyPort.sv */
`include "io_consts.svh"

module keyPort (
  input  logic                    clk,
  input  logic                    reset,
  input  ioPkg::busWordT          addr,
  input  ioPkg::busWordT          wrData,
  input  logic                    we,
  input  logic                    rd,
  input  logic [`IO_KEY_BITS-1:0] key,
  output ioPkg::busWordT          rdData,
  output logic                    keyIrq
);

  localparam int sampleBits = $clog2(`IO_KEY_SAMPLE_CYCLES);
  localparam logic [sampleBits-1:0] sampleLast = sampleBits'(`IO_KEY_SAMPLE_CYCLES - 1);
  localparam ioPkg::busWordT dataAddr = `IO_ADDR_KEY;
  localparam ioPkg::busWordT ctlAddr = `IO_ADDR_KEY + 32'h4;

  logic [sampleBits-1:0] sampleCnt;
  logic [`IO_KEY_BITS-1:0] sample;
  logic [`IO_KEY_BITS-1:0] lastSample;
  logic [`IO_KEY_BITS-1:0] keyData;
  logic samplePoint;
  logic update;
  logic dataRead;
  logic ctlWrite;
  logic readyKept;
  logic ready;
  logic overrun;
  logic irqEnable;

  assign samplePoint = (sampleCnt == sampleLast);
  // Two matching samples that differ from the stored value
  assign update = samplePoint && (sample == lastSample) && (sample != keyData);
  assign dataRead = rd && (addr == dataAddr);
  assign ctlWrite = we && (addr == ctlAddr);
  // A read in the same cycle counts as consumed before a new update
  assign readyKept = ready && !dataRead;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sampleCnt <= '0;
      sample <= '0;
      lastSample <= '0;
      keyData <= '0;
    end else begin
      sampleCnt <= samplePoint ? '0 : sampleCnt + 1'b1;
      if (samplePoint) begin
        // Buttons are active low
        sample <= ~key;
        lastSample <= sample;
      end
      if (update) begin
        keyData <= sample;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ready <= 1'b0;
      overrun <= 1'b0;
      irqEnable <= 1'b0;
    end else begin
      ready <= readyKept;
      if (ctlWrite) begin
        if (!wrData[`IO_CTL_OVERRUN]) begin
          overrun <= 1'b0;
        end
        irqEnable <= wrData[`IO_CTL_IE];
      end
      if (update) begin
        if (readyKept) begin
          overrun <= 1'b1;
        end else begin
          ready <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    rdData = '0;
    if (addr == dataAddr) begin
      rdData[`IO_KEY_BITS-1:0] = keyData;
    end else if (addr == ctlAddr) begin
      rdData[`IO_CTL_READY] = ready;
      rdData[`IO_CTL_OVERRUN] = overrun;
      rdData[`IO_CTL_IE] = irqEnable;
    end
  end

  assign keyIrq = ready && irqEnable;

  keyOverrunNeedsReady: assert property (@(posedge clk) disable iff (reset)
    $rose(overrun) |-> $past(ready));

endmodule

/* rtl/intervalTimer.sv */
`include "io_consts.svh"

module intervalTimer #(
  parameter int cyclesPerMs = 100000
) (
  input  logic           clk,
  input  logic           reset,
  input  ioPkg::busWordT addr,
  input  ioPkg::busWordT wrData,
  input  logic           we,
  output ioPkg::busWordT rdData,
  output logic           timerIrq
);

  localparam int preBits = (cyclesPerMs > 1) ? $clog2(cyclesPerMs) : 1;
  localparam logic [preBits-1:0] preLast = preBits'(cyclesPerMs - 1);
  localparam ioPkg::busWordT cntAddr = `IO_ADDR_TIMER;
  localparam ioPkg::busWordT limAddr = `IO_ADDR_TIMER + 32'h4;
  localparam ioPkg::busWordT ctlAddr = `IO_ADDR_TIMER + 32'h8;

  logic [preBits-1:0] prescale;
  ioPkg::busWordT count;
  ioPkg::busWordT limit;
  ioPkg::busWordT nextCount;
  logic msTick;
  logic wrap;
  logic ctlWrite;
  logic readyKept;
  logic ready;
  logic overrun;
  logic irqEnable;

  assign msTick = (prescale == preLast);
  assign nextCount = count + 1'b1;
  // Limit zero means free running
  assign wrap = msTick && (limit != '0) && (nextCount >= limit);
  assign ctlWrite = we && (addr == ctlAddr);
  assign readyKept = ready && !(ctlWrite && !wrData[`IO_CTL_READY]);

  // Millisecond prescaler
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      prescale <= '0;
    end else if (msTick) begin
      prescale <= '0;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
      limit <= '0;
    end else begin
      if (msTick) begin
        count <= wrap ? '0 : nextCount;
      end
      // Bus writes win over the tick
      if (we && (addr == cntAddr)) begin
        count <= wrData;
      end else if (we && (addr == limAddr)) begin
        limit <= wrData;
        count <= '0;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ready <= 1'b0;
      overrun <= 1'b0;
      irqEnable <= 1'b0;
    end else begin
      ready <= readyKept;
      if (ctlWrite) begin
        if (!wrData[`IO_CTL_OVERRUN]) begin
          overrun <= 1'b0;
        end
        irqEnable <= wrData[`IO_CTL_IE];
      end
      if (wrap) begin
        if (readyKept) begin
          overrun <= 1'b1;
        end else begin
          ready <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    rdData = '0;
    case (addr)
      cntAddr: rdData = count;
      limAddr: rdData = limit;
      ctlAddr: begin
        rdData[`IO_CTL_READY] = ready;
        rdData[`IO_CTL_OVERRUN] = overrun;
        rdData[`IO_CTL_IE] = irqEnable;
      end
      default: rdData = '0;
    endcase
  end

  assign timerIrq = ready && irqEnable;

  timerOverrunNeedsReady: assert property (@(posedge clk) disable iff (reset)
    $rose(overrun) |-> $past(ready));

endmodule

/* rtl/ioSystem.sv */
`include "io_consts.svh"

module ioSystem #(
  parameter int cyclesPerMs = 100000
) (
  input  logic                     clk,
  input  logic                     reset,
  input  ioPkg::busWordT           addr,
  input  ioPkg::busWordT           wrData,
  input  logic                     we,
  input  logic                     rd,
  input  logic [`IO_KEY_BITS-1:0]  key,
  output ioPkg::busWordT           rdData,
  output logic [`IO_LEDR_BITS-1:0] ledr,
  output ioPkg::segmentT           hex0,
  output ioPkg::segmentT           hex1,
  output ioPkg::segmentT           hex2,
  output ioPkg::segmentT           hex3,
  output ioPkg::segmentT           hex4,
  output ioPkg::segmentT           hex5,
  output logic                     irq
);

  ioPkg::busWordT displayRdData;
  ioPkg::busWordT keyRdData;
  ioPkg::busWordT timerRdData;
  logic keyIrq;
  logic timerIrq;

  displayPorts i_display (
    .clk    (clk),
    .reset  (reset),
    .addr   (addr),
    .wrData (wrData),
    .we     (we),
    .rdData (displayRdData),
    .ledr   (ledr),
    .hex0   (hex0),
    .hex1   (hex1),
    .hex2   (hex2),
    .hex3   (hex3),
    .hex4   (hex4),
    .hex5   (hex5)
  );

  keyPort i_key (
    .clk    (clk),
    .reset  (reset),
    .addr   (addr),
    .wrData (wrData),
    .we     (we),
    .rd     (rd),
    .key    (key),
    .rdData (keyRdData),
    .keyIrq (keyIrq)
  );

  intervalTimer #(.cyclesPerMs(cyclesPerMs)) i_timer (
    .clk      (clk),
    .reset    (reset),
    .addr     (addr),
    .wrData   (wrData),
    .we       (we),
    .rdData   (timerRdData),
    .timerIrq (timerIrq)
  );

  // Unselected peripherals return zero, so OR is the read mux
  assign rdData = displayRdData | keyRdData | timerRdData;
  assign irq = keyIrq | timerIrq;

  // One access per cycle on the bus
  noReadDuringWrite: assert property (@(posedge clk) disable iff (reset) !(rd && we));

endmodule

/* sim/ioSystemTb.sv */
`include "io_consts.svh"

module ioSystemTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int maxCycles = 4000;
  localparam ioPkg::busWordT keyCtl = `IO_ADDR_KEY + 32'h4;
  localparam ioPkg::busWordT timerLim = `IO_ADDR_TIMER + 32'h4;
  localparam ioPkg::busWordT timerCtl = `IO_ADDR_TIMER + 32'h8;

  logic clk;
  logic reset;
  ioPkg::busWordT addr;
  ioPkg::busWordT wrData;
  logic we;
  logic rd;
  logic [`IO_KEY_BITS-1:0] key;
  ioPkg::busWordT rdData;
  logic [`IO_LEDR_BITS-1:0] ledr;
  ioPkg::segmentT hex0, hex1, hex2, hex3, hex4, hex5;
  logic irq;
  logic [5:0][6:0] hexAll;

  // Reference model of the register state
  logic [`IO_LEDR_BITS-1:0] modelLedr;
  ioPkg::hexDigitsT modelHex;
  logic [`IO_KEY_BITS-1:0] keyData;
  logic keyReady, keyOverrun, keyIe;
  logic timerReady, timerOverrun, timerIe;
  ioPkg::busWordT modelCount;
  ioPkg::busWordT modelLimit;

  // Requests from the stimulus to the comparing process
  logic checkRead;
  ioPkg::busWordT expRead;
  string readName;
  logic checkIrq;
  logic expIrq;

  logic [31:0] rngState = 32'h91afebdc;
  int cycleCount = 0;

  ioSystem #(.cyclesPerMs(5)) i_dut (
    .clk    (clk),
    .reset  (reset),
    .addr   (addr),
    .wrData (wrData),
    .we     (we),
    .rd     (rd),
    .key    (key),
    .rdData (rdData),
    .ledr   (ledr),
    .hex0   (hex0),
    .hex1   (hex1),
    .hex2   (hex2),
    .hex3   (hex3),
    .hex4   (hex4),
    .hex5   (hex5),
    .irq    (irq)
  );

  assign hexAll = {hex5, hex4, hex3, hex2, hex1, hex0};

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Lit segment bits in g..a order before the active-low inversion
  function automatic ioPkg::segmentT segRef(input logic [3:0] digit);
    logic [6:0] lit;
    case (digit)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  function automatic ioPkg::busWordT ctlWord(input logic rdy, input logic ovr, input logic ie);
    ioPkg::busWordT word;
    word = '0;
    word[`IO_CTL_READY] = rdy;
    word[`IO_CTL_OVERRUN] = ovr;
    word[`IO_CTL_IE] = ie;
    return word;
  endfunction

  function automatic ioPkg::busWordT expectedRead(input ioPkg::busWordT a);
    ioPkg::busWordT word;
    word = '0;
    case (a)
      `IO_ADDR_LEDR: word[`IO_LEDR_BITS-1:0] = modelLedr;
      `IO_ADDR_HEX: word[23:0] = modelHex;
      `IO_ADDR_KEY: word[`IO_KEY_BITS-1:0] = keyData;
      keyCtl: word = ctlWord(keyReady, keyOverrun, keyIe);
      `IO_ADDR_TIMER: word = modelCount;
      timerLim: word = modelLimit;
      timerCtl: word = ctlWord(timerReady, timerOverrun, timerIe);
      default: word = '0;
    endcase
    return word;
  endfunction

  // Next pattern that is sure to differ from the current one
  function automatic logic [3:0] newKeys(input logic [3:0] cur, input logic [31:0] rnd);
    logic [3:0] p;
    p = rnd[3:0];
    if (p == cur) begin
      p = ~p;
    end
    return p;
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    $display("[ERROR] t=%0t %s expected %0h actual %0h", $time, name, expVal, actVal);
    $display("Simulation failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  task automatic applyWrite(input ioPkg::busWordT a, input ioPkg::busWordT d);
    case (a)
      `IO_ADDR_LEDR: modelLedr = d[`IO_LEDR_BITS-1:0];
      `IO_ADDR_HEX: modelHex = d[23:0];
      keyCtl: begin
        if (!d[`IO_CTL_OVERRUN]) keyOverrun = 1'b0;
        keyIe = d[`IO_CTL_IE];
      end
      `IO_ADDR_TIMER: modelCount = d;
      timerLim: begin
        modelLimit = d;
        modelCount = '0;
      end
      timerCtl: begin
        if (!d[`IO_CTL_READY]) timerReady = 1'b0;
        if (!d[`IO_CTL_OVERRUN]) timerOverrun = 1'b0;
        timerIe = d[`IO_CTL_IE];
      end
      default: ;
    endcase
  endtask

  // Bus tasks start and end 0.5 ns after a rising edge
  task automatic busWrite(input ioPkg::busWordT a, input ioPkg::busWordT d);
    addr = a;
    wrData = d;
    we = 1'b1;
    @(posedge clk);
    #0.5;
    we = 1'b0;
    applyWrite(a, d);
  endtask

  task automatic busRead(input ioPkg::busWordT a, input logic strobe,
                         output ioPkg::busWordT data);
    addr = a;
    rd = strobe;
    @(negedge clk);
    data = rdData;
    @(posedge clk);
    #0.5;
    rd = 1'b0;
    if (strobe && a == `IO_ADDR_KEY) keyReady = 1'b0;
  endtask

  task automatic checkedRead(input ioPkg::busWordT a, input string name);
    ioPkg::busWordT data;
    expRead = expectedRead(a);
    readName = name;
    checkRead = 1'b1;
    busRead(a, 1'b1, data);
    checkRead = 1'b0;
  endtask

  task automatic expectIrq();
    expIrq = (keyReady && keyIe) || (timerReady && timerIe);
    checkIrq = 1'b1;
    @(posedge clk);
    #0.5;
    checkIrq = 1'b0;
  endtask

  task automatic pollStatus(input ioPkg::busWordT a, input int bitPos, input int limit,
                            input string what);
    ioPkg::busWordT word;
    int n;
    word = '0;
    n = 0;
    while (!word[bitPos]) begin
      if (n == limit) abortRun($sformatf("%s was not set within %0d cycles", what, limit));
      busRead(a, 1'b1, word);
      n++;
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      assert (ledr == modelLedr) else reportMismatch("ledr", modelLedr, ledr);
      for (int i = 0; i < 6; i++) begin
        assert (hexAll[i] == segRef(modelHex[i]))
          else reportMismatch($sformatf("hex%0d", i), segRef(modelHex[i]), hexAll[i]);
      end
      if (checkRead) begin
        assert (rdData == expRead) else reportMismatch(readName, expRead, rdData);
      end
      if (checkIrq) begin
        assert (irq == expIrq) else reportMismatch("irq", expIrq, irq);
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= maxCycles) abortRun("Timeout, the run did not finish in time");
  end

  initial begin
    ioPkg::busWordT cnt;
    logic [3:0] keysNow;
    clk = 1'b0;
    reset = 1'b1;
    addr = '0;
    wrData = '0;
    we = 1'b0;
    rd = 1'b0;
    key = '1;
    keysNow = '1;
    checkRead = 1'b0;
    checkIrq = 1'b0;
    expRead = '0;
    expIrq = 1'b0;
    modelLedr = '0;
    modelHex = `IO_HEX_RESET;
    keyData = '0;
    {keyReady, keyOverrun, keyIe} = '0;
    {timerReady, timerOverrun, timerIe} = '0;
    modelCount = '0;
    modelLimit = '0;
    repeat (5) @(posedge clk);
    #0.5;
    reset = 1'b0;

    checkedRead(`IO_ADDR_LEDR, "ledrRead");
    checkedRead(`IO_ADDR_HEX, "hexRead");
    checkedRead(`IO_ADDR_KEY, "keyData");
    checkedRead(keyCtl, "keyCtl");
    checkedRead(timerLim, "timerLimit");
    checkedRead(timerCtl, "timerCtl");
    expectIrq();

    repeat (20) begin
      rngState = xorshift32(rngState);
      busWrite(`IO_ADDR_LEDR, rngState);
      rngState = xorshift32(rngState);
      busWrite(`IO_ADDR_HEX, rngState);
      checkedRead(`IO_ADDR_LEDR, "ledrRead");
      checkedRead(`IO_ADDR_HEX, "hexRead");
    end

    // Button port with its interrupt enabled
    busWrite(keyCtl, 32'h10);
    expectIrq();
    rngState = xorshift32(rngState);
    keysNow = newKeys(keysNow, rngState);
    key = keysNow;
    pollStatus(keyCtl, `IO_CTL_READY, 64, "Button ready");
    keyReady = 1'b1;
    keyData = ~keysNow;
    checkedRead(keyCtl, "keyCtl");
    expectIrq();
    checkedRead(`IO_ADDR_KEY, "keyData");
    checkedRead(keyCtl, "keyCtl");
    expectIrq();

    // Two changes without a data read in between
    rngState = xorshift32(rngState);
    keysNow = newKeys(keysNow, rngState);
    key = keysNow;
    pollStatus(keyCtl, `IO_CTL_READY, 64, "Button ready");
    keyReady = 1'b1;
    keyData = ~keysNow;
    expectIrq();
    rngState = xorshift32(rngState);
    keysNow = newKeys(keysNow, rngState);
    key = keysNow;
    pollStatus(keyCtl, `IO_CTL_OVERRUN, 64, "Button overrun");
    keyOverrun = 1'b1;
    keyData = ~keysNow;
    checkedRead(keyCtl, "keyCtl");
    busWrite(keyCtl, 32'h10);
    checkedRead(keyCtl, "keyCtl");
    expectIrq();
    checkedRead(`IO_ADDR_KEY, "keyData");
    expectIrq();

    // Interval timer
    rngState = xorshift32(rngState);
    busWrite(`IO_ADDR_TIMER, rngState);
    checkedRead(`IO_ADDR_TIMER, "timerCount");
    busWrite(timerLim, 32'd3);
    // A limit write clears the count before the next tick
    checkedRead(`IO_ADDR_TIMER, "timerCount");
    pollStatus(timerCtl, `IO_CTL_READY, 40, "Timer ready");
    timerReady = 1'b1;
    checkedRead(timerCtl, "timerCtl");
    busRead(`IO_ADDR_TIMER, 1'b1, cnt);
    assert (cnt < 32'd3) else reportMismatch("timerCount below limit 3", 32'd2, cnt);
    pollStatus(timerCtl, `IO_CTL_OVERRUN, 40, "Timer overrun");
    timerOverrun = 1'b1;
    checkedRead(timerCtl, "timerCtl");
    busWrite(timerCtl, 32'h13);
    expectIrq();
    // Stop wrapping so the clear below cannot race a new event
    busWrite(timerLim, 32'd0);
    busWrite(timerCtl, 32'h10);
    checkedRead(timerCtl, "timerCtl");
    checkedRead(timerLim, "timerLimit");
    expectIrq();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+include
rtl/ioPkg.sv
rtl/displayPorts.sv
rtl/keyPort.sv
rtl/intervalTimer.sv
rtl/ioSystem.sv
sim/ioSystemTb.sv
